// File: flist.f
common/l2_pkg.sv
l2_store/l2_tag_array.sv
l2_store/l2_data_array.sv
l2_store/l2_plru.sv
l2_ctrl/l2_req_buffer.sv
l2_ctrl/l2_main_fsm.sv
design/l2_cache_top.sv
testbench/tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L2 cache testbench with Verilator

verilator --binary --timing -f flist.f --top-module tb_l2_cache -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_l2_cache.sv
module tb_l2_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import l2_pkg::*;

    localparam int NUM_REQ      = 600;
    localparam int LIMIT_CYCLES = NUM_REQ * 40;

    logic  clk;
    logic  rstn;
    logic  icache_req;
    addr_t icache_addr;
    logic  dcache_req;
    logic  dcache_wr;
    addr_t dcache_addr;
    word_t dcache_wdata;
    logic  icache_addr_ok;
    logic  icache_data_ok;
    word_t icache_rdata;
    logic  dcache_addr_ok;
    logic  dcache_data_ok;
    word_t dcache_rdata;
    logic  mem_req_r;
    logic  mem_req_w;
    logic  mem_rdy;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_addr_ok_w;
    logic  mem_addr_ok_r;
    logic  mem_data_ok;
    word_t mem_rdata;

    // values seen at the last rising edge
    logic  s_iaok, s_daok, s_idok, s_ddok;
    logic  s_req_r, s_req_w, s_rdy, s_aok_w, s_aok_r, s_dok;
    word_t s_idata, s_ddata, s_mwdata;
    addr_t s_maddr;

    integer seed = 32'h143c;
    int     errors = 0;
    int     checks = 0;

    // memory responder
    word_t mem_q [addr_t];
    int    w_wait = -1;
    int    r_wait = -1;
    int    d_wait = -1;
    addr_t rd_line;

    // memory events of the request in flight
    int    wb_cnt, rd_cnt;
    addr_t wb_addr_l, rd_addr_l;
    word_t wb_data_l;
    logic  order_bad;

    // expected events of the request in flight
    logic  e_valid = 1'b0;
    logic  e_wb, e_miss;
    addr_t e_wb_addr, e_rd_addr;
    word_t e_wb_data;

    // reference cache contents
    logic       m_valid [NUM_SETS][NUM_WAYS];
    logic       m_dirty [NUM_SETS][NUM_WAYS];
    tag_t       m_tag   [NUM_SETS][NUM_WAYS];
    word_t      m_data  [NUM_SETS][NUM_WAYS];
    logic [2:0] m_tree  [NUM_SETS];

    l2_cache_top u_dut (
        .clk              (clk),
        .rstn             (rstn),
        .icache_req_i     (icache_req),
        .icache_addr_i    (icache_addr),
        .icache_addr_ok_o (icache_addr_ok),
        .icache_data_ok_o (icache_data_ok),
        .icache_rdata_o   (icache_rdata),
        .dcache_req_i     (dcache_req),
        .dcache_wr_i      (dcache_wr),
        .dcache_addr_i    (dcache_addr),
        .dcache_wdata_i   (dcache_wdata),
        .dcache_addr_ok_o (dcache_addr_ok),
        .dcache_data_ok_o (dcache_data_ok),
        .dcache_rdata_o   (dcache_rdata),
        .mem_req_r_o      (mem_req_r),
        .mem_req_w_o      (mem_req_w),
        .mem_rdy_o        (mem_rdy),
        .mem_addr_o       (mem_addr),
        .mem_wdata_o      (mem_wdata),
        .mem_addr_ok_w_i  (mem_addr_ok_w),
        .mem_addr_ok_r_i  (mem_addr_ok_r),
        .mem_data_ok_i    (mem_data_ok),
        .mem_rdata_i      (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    // untouched words read as a pattern of the whole address
    function automatic word_t mem_read(input addr_t a);
        if (mem_q.exists(a)) begin
            return mem_q[a];
        end
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // bit 0 selects the pair and the pair's own bit selects the way
    function automatic way_t plru_victim(input logic [2:0] t);
        if (t[0] == 1'b0) begin
            return t[1] ? way_t'(1) : way_t'(0);
        end
        return t[2] ? way_t'(3) : way_t'(2);
    endfunction

    task automatic plru_use(input index_t idx, input way_t w);
        // turn the path away from the used way
        m_tree[idx][0] = (w < 2);
        if (w < 2) begin
            m_tree[idx][1] = (w == 0);
        end else begin
            m_tree[idx][2] = (w == 2);
        end
    endtask

    //////////////////////////////
    // sample at the rising edge and answer at the falling edge
    //////////////////////////////
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        s_iaok   = icache_addr_ok;
        s_daok   = dcache_addr_ok;
        s_idok   = icache_data_ok;
        s_ddok   = dcache_data_ok;
        s_idata  = icache_rdata;
        s_ddata  = dcache_rdata;
        s_req_r  = mem_req_r;
        s_req_w  = mem_req_w;
        s_rdy    = mem_rdy;
        s_maddr  = mem_addr;
        s_mwdata = mem_wdata;
        s_aok_w  = mem_addr_ok_w;
        s_aok_r  = mem_addr_ok_r;
        s_dok    = mem_data_ok;
        @(negedge clk);
        check(!(s_dok && !s_rdy), "memory data returned while not ready");
        // write-back channel
        if (s_req_w && s_aok_w) begin
            wb_cnt++;
            wb_addr_l = s_maddr;
            wb_data_l = s_mwdata;
            order_bad = order_bad | (rd_cnt != 0);
            mem_q[s_maddr] = s_mwdata;
            mem_addr_ok_w = 1'b0;
            w_wait = -1;
        end else if (s_req_w) begin
            r = $random(seed);
            if (w_wait < 0) w_wait = int'(r & 32'd3);
            if (w_wait == 0) mem_addr_ok_w = 1'b1;
            else w_wait--;
        end
        // refill address channel
        if (s_req_r && s_aok_r) begin
            rd_cnt++;
            rd_addr_l = s_maddr;
            rd_line = s_maddr;
            mem_addr_ok_r = 1'b0;
            r_wait = -1;
            r = $random(seed);
            d_wait = int'(r & 32'd3);
        end else if (s_req_r) begin
            r = $random(seed);
            if (r_wait < 0) r_wait = int'(r & 32'd3);
            if (r_wait == 0) mem_addr_ok_r = 1'b1;
            else r_wait--;
        end
        // refill data channel
        if (s_dok && s_rdy) begin
            mem_data_ok = 1'b0;
        end else if (d_wait == 0) begin
            mem_data_ok = 1'b1;
            mem_rdata = mem_read(rd_line);
            d_wait = -1;
        end else if (d_wait > 0) begin
            d_wait--;
        end
    endtask

    task automatic check_events();
        if (e_valid) begin
            check(wb_cnt == (e_wb ? 1 : 0), "write-back count differs from the model");
            if (e_wb && wb_cnt == 1) begin
                check(wb_addr_l == e_wb_addr, "write-back line address");
                check(wb_data_l == e_wb_data, "write-back data word");
            end
            check(rd_cnt == (e_miss ? 1 : 0), "refill count differs from the model");
            if (e_miss && rd_cnt == 1) begin
                check(rd_addr_l == e_rd_addr, "refill line address");
            end
            check(!order_bad, "refill issued before the write-back");
        end
        wb_cnt    = 0;
        rd_cnt    = 0;
        order_bad = 1'b0;
    endtask

    // update the model and note the memory traffic to expect
    task automatic predict(input logic wr, input addr_t addr, input word_t wdata,
                           output logic hit, output word_t rd_word);
        index_t idx;
        tag_t   tg;
        way_t   hw;
        way_t   v;
        idx = addr[5:2];
        tg  = addr[31:6];
        hit = 1'b0;
        hw  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                hit = 1'b1;
                hw  = way_t'(w);
            end
        end
        e_valid   = 1'b1;
        e_wb      = 1'b0;
        e_miss    = !hit;
        e_rd_addr = {tg, idx, 2'b00};
        if (hit) begin
            if (wr) begin
                m_data[idx][hw]  = wdata;
                m_dirty[idx][hw] = 1'b1;
            end
            rd_word = m_data[idx][hw];
            plru_use(idx, hw);
        end else begin
            v = plru_victim(m_tree[idx]);
            e_wb      = m_valid[idx][v] && m_dirty[idx][v];
            e_wb_addr = {m_tag[idx][v], idx, 2'b00};
            e_wb_data = m_data[idx][v];
            rd_word   = mem_read(e_rd_addr);
            m_valid[idx][v] = 1'b1;
            m_tag[idx][v]   = tg;
            m_dirty[idx][v] = wr;
            m_data[idx][v]  = wr ? wdata : rd_word;
            plru_use(idx, v);
        end
    endtask

    //////////////////////////////
    // one request from start to end
    //////////////////////////////
    task automatic issue(input logic is_d, input logic wr, input addr_t addr,
                         input word_t wdata);
        logic  hit;
        word_t exp_word;
        int    lat;
        if (is_d) begin
            dcache_req   = 1'b1;
            dcache_wr    = wr;
            dcache_addr  = addr;
            dcache_wdata = wdata;
        end else begin
            icache_req  = 1'b1;
            icache_addr = addr;
        end
        do begin
            tick();
            check(!(is_d ? s_iaok : s_daok), "addr-ok raised for the wrong source");
            check(!s_idok && !s_ddok, "data-ok while no read is in flight");
        end while (!(is_d ? s_daok : s_iaok));
        if (is_d) dcache_req = 1'b0;
        else icache_req = 1'b0;
        check_events();
        predict(wr, addr, wdata, hit, exp_word);
        if (!wr) begin
            lat = 0;
            do begin
                tick();
                lat++;
                check(!(is_d ? s_idok : s_ddok), "data-ok raised for the wrong source");
                if (hit) check(!s_req_r && !s_req_w, "memory request on a read hit");
            end while (!(is_d ? s_ddok : s_idok));
            if (hit) check(lat == 1, "read hit data-ok not 1 cycle after addr-ok");
            else check(s_dok, "read miss done without memory data-ok");
            check((is_d ? s_ddata : s_idata) == exp_word, "read data differs from the model");
        end
    endtask

    initial begin
        logic [31:0] r;
        addr_t       a;
        addr_t       ia;
        rstn          = 1'b0;
        icache_req    = 1'b0;
        icache_addr   = '0;
        dcache_req    = 1'b0;
        dcache_wr     = 1'b0;
        dcache_addr   = '0;
        dcache_wdata  = '0;
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        wb_cnt        = 0;
        rd_cnt        = 0;
        order_bad     = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_tree[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_data[s][w]  = '0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        tick();
        check(!s_iaok && !s_daok && !s_idok && !s_ddok, "handshake output high after reset");
        check(!s_req_r && !s_req_w && !s_rdy, "memory request high after reset");

        for (int n = 0; n < NUM_REQ; n++) begin
            r = $random(seed);
            // 8 tags over sets 1, 5, 9 and 13
            a  = {23'h1a2b3c, r[10:8], r[12:11], 2'b01, 2'b00};
            ia = {23'h1a2b3c, r[15:13], r[17:16], 2'b01, 2'b00};
            if (r[0] | r[1]) begin
                if (r[5:3] == 3'd0) begin
                    // both sides in the same cycle
                    icache_req  = 1'b1;
                    icache_addr = ia;
                    issue(1'b1, r[2], a, $random(seed));
                    issue(1'b0, 1'b0, ia, '0);
                end else begin
                    issue(1'b1, r[2], a, $random(seed));
                end
            end else begin
                issue(1'b0, 1'b0, a, '0);
            end
        end
        // drain the last request
        issue(1'b0, 1'b0, 32'h0000_0040, '0);
        check_events();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: design/l2_cache_top.sv
module l2_cache_top (
    input  logic            clk,
    input  logic            rstn,
    // icache side
    input  logic            icache_req_i,
    input  l2_pkg::addr_t   icache_addr_i,
    output logic            icache_addr_ok_o,
    output logic            icache_data_ok_o,
    output l2_pkg::word_t   icache_rdata_o,
    // dcache side
    input  logic            dcache_req_i,
    input  logic            dcache_wr_i,
    input  l2_pkg::addr_t   dcache_addr_i,
    input  l2_pkg::word_t   dcache_wdata_i,
    output logic            dcache_addr_ok_o,
    output logic            dcache_data_ok_o,
    output l2_pkg::word_t   dcache_rdata_o,
    // memory side
    output logic            mem_req_r_o,
    output logic            mem_req_w_o,
    output logic            mem_rdy_o,
    output l2_pkg::addr_t   mem_addr_o,
    output l2_pkg::word_t   mem_wdata_o,
    input  logic            mem_addr_ok_w_i,
    input  logic            mem_addr_ok_r_i,
    input  logic            mem_data_ok_i,
    input  l2_pkg::word_t   mem_rdata_i
);
    import l2_pkg::*;

    // held request
    logic      req_pending;
    logic      accept;
    index_t    req_index;
    tag_t      req_tag;
    src_e      req_src;
    logic      req_wr;
    word_t     req_wdata;

    // storage handshakes
    way_mask_t hit_mask;
    way_mask_t use_mask;
    way_mask_t data_we;
    way_mask_t tag_we;
    way_mask_t dirty_set;
    logic      data_sel_mem;
    way_t      plru_victim;
    way_t      sel_way;
    tag_t      sel_tag;
    logic      sel_dirty;
    word_t     hit_word;
    word_t     sel_word;
    word_t     ret_word;

    l2_req_buffer u_req_buffer (
        .clk              (clk),
        .rstn             (rstn),
        .icache_req_i     (icache_req_i),
        .icache_addr_i    (icache_addr_i),
        .dcache_req_i     (dcache_req_i),
        .dcache_wr_i      (dcache_wr_i),
        .dcache_addr_i    (dcache_addr_i),
        .dcache_wdata_i   (dcache_wdata_i),
        .accept_i         (accept),
        .icache_addr_ok_o (icache_addr_ok_o),
        .dcache_addr_ok_o (dcache_addr_ok_o),
        .req_index_o      (req_index),
        .req_tag_o        (req_tag),
        .req_src_o        (req_src),
        .req_wr_o         (req_wr),
        .req_wdata_o      (req_wdata),
        .req_pending_o    (req_pending)
    );

    l2_main_fsm u_main_fsm (
        .clk              (clk),
        .rstn             (rstn),
        .req_pending_i    (req_pending),
        .req_src_i        (req_src),
        .req_wr_i         (req_wr),
        .req_index_i      (req_index),
        .req_tag_i        (req_tag),
        .hit_mask_i       (hit_mask),
        .victim_way_i     (plru_victim),
        .victim_dirty_i   (sel_dirty),
        .victim_tag_i     (sel_tag),
        .victim_word_i    (sel_word),
        .hit_word_i       (hit_word),
        .mem_addr_ok_w_i  (mem_addr_ok_w_i),
        .mem_addr_ok_r_i  (mem_addr_ok_r_i),
        .mem_data_ok_i    (mem_data_ok_i),
        .mem_rdata_i      (mem_rdata_i),
        .accept_o         (accept),
        .icache_data_ok_o (icache_data_ok_o),
        .dcache_data_ok_o (dcache_data_ok_o),
        .rdata_o          (ret_word),
        .mem_req_r_o      (mem_req_r_o),
        .mem_req_w_o      (mem_req_w_o),
        .mem_rdy_o        (mem_rdy_o),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .use_o            (use_mask),
        .data_we_o        (data_we),
        .data_sel_mem_o   (data_sel_mem),
        .tag_we_o         (tag_we),
        .dirty_set_o      (dirty_set),
        .sel_way_o        (sel_way)
    );

    l2_tag_array u_tag_array (
        .clk         (clk),
        .rstn        (rstn),
        .index_i     (req_index),
        .tag_i       (req_tag),
        .tag_we_i    (tag_we),
        .dirty_set_i (dirty_set),
        .sel_way_i   (sel_way),
        .hit_mask_o  (hit_mask),
        .sel_tag_o   (sel_tag),
        .sel_dirty_o (sel_dirty)
    );

    l2_data_array u_data_array (
        .clk        (clk),
        .index_i    (req_index),
        .we_i       (data_we),
        .sel_mem_i  (data_sel_mem),
        .mem_word_i (mem_rdata_i),
        .wdata_i    (req_wdata),
        .hit_mask_i (hit_mask),
        .sel_way_i  (sel_way),
        .hit_word_o (hit_word),
        .sel_word_o (sel_word)
    );

    l2_plru u_plru (
        .clk      (clk),
        .rstn     (rstn),
        .index_i  (req_index),
        .use_i    (use_mask),
        .victim_o (plru_victim)
    );

    // both sides see the return mux, data-ok qualifies it
    assign icache_rdata_o = ret_word;
    assign dcache_rdata_o = ret_word;

endmodule

// File: l2_ctrl/l2_main_fsm.sv
module l2_main_fsm (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_pending_i,
    input  l2_pkg::src_e      req_src_i,
    input  logic              req_wr_i,
    input  l2_pkg::index_t    req_index_i,
    input  l2_pkg::tag_t      req_tag_i,
    input  l2_pkg::way_mask_t hit_mask_i,
    input  l2_pkg::way_t      victim_way_i,
    input  logic              victim_dirty_i,
    input  l2_pkg::tag_t      victim_tag_i,
    input  l2_pkg::word_t     victim_word_i,
    input  l2_pkg::word_t     hit_word_i,
    input  logic              mem_addr_ok_w_i,
    input  logic              mem_addr_ok_r_i,
    input  logic              mem_data_ok_i,
    input  l2_pkg::word_t     mem_rdata_i,
    output logic              accept_o,
    output logic              icache_data_ok_o,
    output logic              dcache_data_ok_o,
    output l2_pkg::word_t     rdata_o,
    output logic              mem_req_r_o,
    output logic              mem_req_w_o,
    output logic              mem_rdy_o,
    output l2_pkg::addr_t     mem_addr_o,
    output l2_pkg::word_t     mem_wdata_o,
    output l2_pkg::way_mask_t use_o,
    output l2_pkg::way_mask_t data_we_o,
    output logic              data_sel_mem_o,
    output l2_pkg::way_mask_t tag_we_o,
    output l2_pkg::way_mask_t dirty_set_o,
    output l2_pkg::way_t      sel_way_o
);
    import l2_pkg::*;

    l2_state_e state_q;
    l2_state_e state_d;
    way_t      victim_q;
    way_mask_t victim_mask;
    logic      hit;
    logic      rd_done;

    assign hit         = |hit_mask_i;
    assign victim_mask = way_mask_t'(1) << victim_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim is frozen at the dirty check
    always_ff @(posedge clk) begin
        if (!rstn) begin
            victim_q <= '0;
        end else if (state_q == CHECK_DIRTY) begin
            victim_q <= victim_way_i;
        end
    end

    //////////////////////////////
    // next state and strobes
    //////////////////////////////
    always_comb begin
        state_d        = state_q;
        accept_o       = 1'b0;
        rd_done        = 1'b0;
        mem_req_r_o    = 1'b0;
        mem_req_w_o    = 1'b0;
        mem_rdy_o      = 1'b0;
        use_o          = '0;
        data_we_o      = '0;
        data_sel_mem_o = 1'b0;
        tag_we_o       = '0;
        dirty_set_o    = '0;
        case (state_q)
            IDLE: begin
                accept_o = req_pending_i;
                if (req_pending_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    use_o   = hit_mask_i;
                    state_d = IDLE;
                    if (req_wr_i) begin
                        data_we_o   = hit_mask_i;
                        dirty_set_o = hit_mask_i;
                    end else begin
                        rd_done = 1'b1;
                    end
                end else begin
                    state_d = CHECK_DIRTY;
                end
            end
            CHECK_DIRTY: begin
                state_d = victim_dirty_i ? WRITEBACK : REFILL_REQ;
            end
            WRITEBACK: begin
                mem_req_w_o = 1'b1;
                if (mem_addr_ok_w_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_r_o = 1'b1;
                if (mem_addr_ok_r_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                mem_rdy_o = 1'b1;
                if (mem_data_ok_i) begin
                    // fill the line, valid and clean
                    tag_we_o       = victim_mask;
                    data_we_o      = victim_mask;
                    data_sel_mem_o = 1'b1;
                    if (req_wr_i) begin
                        state_d = WRITE_MERGE;
                    end else begin
                        use_o   = victim_mask;
                        rd_done = 1'b1;
                        state_d = IDLE;
                    end
                end
            end
            WRITE_MERGE: begin
                // store word lands on top of the refilled line
                data_we_o   = victim_mask;
                dirty_set_o = victim_mask;
                use_o       = victim_mask;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign icache_data_ok_o = rd_done & (req_src_i == SRC_ICACHE);
    assign dcache_data_ok_o = rd_done & (req_src_i == SRC_DCACHE);

    // return mux: refill word or hit word
    assign rdata_o = (state_q == REFILL_WAIT) ? mem_rdata_i : hit_word_i;

    assign sel_way_o = (state_q == CHECK_DIRTY) ? victim_way_i : victim_q;

    // write-back uses the victim tag, refill the held one
    assign mem_addr_o = (state_q == WRITEBACK) ?
                        {victim_tag_i, req_index_i, {OFFSET_W{1'b0}}} :
                        {req_tag_i, req_index_i, {OFFSET_W{1'b0}}};
    assign mem_wdata_o = victim_word_i;

endmodule

// File: l2_ctrl/l2_req_buffer.sv
module l2_req_buffer (
    input  logic           clk,
    input  logic           rstn,
    input  logic           icache_req_i,
    input  l2_pkg::addr_t  icache_addr_i,
    input  logic           dcache_req_i,
    input  logic           dcache_wr_i,
    input  l2_pkg::addr_t  dcache_addr_i,
    input  l2_pkg::word_t  dcache_wdata_i,
    input  logic           accept_i,
    output logic           icache_addr_ok_o,
    output logic           dcache_addr_ok_o,
    output l2_pkg::index_t req_index_o,
    output l2_pkg::tag_t   req_tag_o,
    output l2_pkg::src_e   req_src_o,
    output logic           req_wr_o,
    output l2_pkg::word_t  req_wdata_o,
    output logic           req_pending_o
);
    import l2_pkg::*;

    logic  grant_d;
    logic  grant_i;
    addr_t addr_q;

    // dcache wins a tie
    assign grant_d = dcache_req_i;
    assign grant_i = icache_req_i & ~dcache_req_i;

    assign req_pending_o    = icache_req_i | dcache_req_i;
    assign dcache_addr_ok_o = accept_i & grant_d;
    assign icache_addr_ok_o = accept_i & grant_i;

    // control fields
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_src_o <= SRC_ICACHE;
            req_wr_o  <= 1'b0;
        end else if (accept_i && req_pending_o) begin
            req_src_o <= grant_d ? SRC_DCACHE : SRC_ICACHE;
            req_wr_o  <= grant_d & dcache_wr_i;
        end
    end

    // address and write payload
    always_ff @(posedge clk) begin
        if (accept_i && req_pending_o) begin
            addr_q      <= grant_d ? dcache_addr_i : icache_addr_i;
            req_wdata_o <= dcache_wdata_i;
        end
    end

    assign req_index_o = addr_q[OFFSET_W +: INDEX_W];
    assign req_tag_o   = addr_q[OFFSET_W + INDEX_W +: TAG_W];

endmodule

// File: l2_store/l2_plru.sv
module l2_plru (
    input  logic              clk,
    input  logic              rstn,
    input  l2_pkg::index_t    index_i,
    input  l2_pkg::way_mask_t use_i,
    output l2_pkg::way_t      victim_o
);
    import l2_pkg::*;

    // bit 0 picks the pair, bit 1 ways 0-1, bit 2 ways 2-3
    logic [2:0] tree_q [NUM_SETS];
    logic [2:0] cur;
    way_t       use_way;

    assign cur = tree_q[index_i];

    // use mask is one-hot
    always_comb begin
        use_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (use_i[w]) begin
                use_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (|use_i) begin
            // point every node on the path away from the used way
            tree_q[index_i][0] <= ~use_way[1];
            if (use_way[1]) begin
                tree_q[index_i][2] <= ~use_way[0];
            end else begin
                tree_q[index_i][1] <= ~use_way[0];
            end
        end
    end

    assign victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

endmodule

// File: l2_store/l2_data_array.sv
module l2_data_array (
    input  logic              clk,
    input  l2_pkg::index_t    index_i,
    input  l2_pkg::way_mask_t we_i,
    input  logic              sel_mem_i,
    input  l2_pkg::word_t     mem_word_i,
    input  l2_pkg::word_t     wdata_i,
    input  l2_pkg::way_mask_t hit_mask_i,
    input  l2_pkg::way_t      sel_way_i,
    output l2_pkg::word_t     hit_word_o,
    output l2_pkg::word_t     sel_word_o
);
    import l2_pkg::*;

    word_t data_q [NUM_WAYS][NUM_SETS];
    word_t wr_word;

    // refill word or store word
    assign wr_word = sel_mem_i ? mem_word_i : wdata_i;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (we_i[w]) begin
                data_q[w][index_i] <= wr_word;
            end
        end
    end

    always_comb begin
        hit_word_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_mask_i[w]) begin
                hit_word_o = data_q[w][index_i];
            end
        end
    end

    assign sel_word_o = data_q[sel_way_i][index_i];

endmodule

// File: l2_store/l2_tag_array.sv
module l2_tag_array (
    input  logic              clk,
    input  logic              rstn,
    input  l2_pkg::index_t    index_i,
    input  l2_pkg::tag_t      tag_i,
    input  l2_pkg::way_mask_t tag_we_i,
    input  l2_pkg::way_mask_t dirty_set_i,
    input  l2_pkg::way_t      sel_way_i,
    output l2_pkg::way_mask_t hit_mask_o,
    output l2_pkg::tag_t      sel_tag_o,
    output logic              sel_dirty_o
);
    import l2_pkg::*;

    tag_t      tag_q   [NUM_WAYS][NUM_SETS];
    way_mask_t valid_q [NUM_SETS];
    way_mask_t dirty_q [NUM_SETS];

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (tag_we_i[w]) begin
                    valid_q[index_i][w] <= 1'b1;
                    dirty_q[index_i][w] <= 1'b0;
                end else if (dirty_set_i[w]) begin
                    dirty_q[index_i][w] <= 1'b1;
                end
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_we_i[w]) begin
                tag_q[w][index_i] <= tag_i;
            end
        end
    end

    // parallel compare across ways
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_mask_o[w] = valid_q[index_i][w] && (tag_q[w][index_i] == tag_i);
        end
    end

    assign sel_tag_o   = tag_q[sel_way_i][index_i];
    assign sel_dirty_o = valid_q[index_i][sel_way_i] & dirty_q[index_i][sel_way_i];

endmodule

// File: common/l2_pkg.sv
package l2_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 16;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 26;
    localparam int WORD_W   = 32;

    //////////////////////////////
    // vector types
    //////////////////////////////
    // byte address, tag | index | offset
    typedef logic [31:0]           addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [1:0]            way_t;
    // one bit per way
    typedef logic [NUM_WAYS-1:0]   way_mask_t;

    // main controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        CHECK_DIRTY,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        WRITE_MERGE
    } l2_state_e;

    // who issued the held request
    typedef enum logic {
        SRC_ICACHE,
        SRC_DCACHE
    } src_e;

endpackage
